/* ex_golden.txt */
# hex: en br op rd rs1 rs2 rs1_val rs2_val imm alu_rd alu_ld alu_fwd mm_rd mm_ld mm_alu mm_mdata
# wb_rd wb_data stall, then expected: result rs2_out rd op update_rd mm_load_out
1 0 1 3 1 2 5 3 0 0 0 0 0 0 0 0 0 0 0  8 3 3 1 1 0
1 0 2 3 1 2 3 5 0 0 0 0 0 0 0 0 0 0 0  fffffffffffffffe 5 3 2 1 0
1 0 a 3 1 2 f0f0 ff00 0 0 0 0 0 0 0 0 0 0 0  f000 ff00 3 a 1 0
1 0 9 3 1 2 f0f0 ff00 0 0 0 0 0 0 0 0 0 0 0  fff0 ff00 3 9 1 0
1 0 6 3 1 2 f0f0 ff00 0 0 0 0 0 0 0 0 0 0 0  ff0 ff00 3 6 1 0
1 0 3 3 1 2 1 3f 0 0 0 0 0 0 0 0 0 0 0  8000000000000000 3f 3 3 1 0
1 0 7 3 1 2 8000000000000000 4 0 0 0 0 0 0 0 0 0 0 0  800000000000000 4 3 7 1 0
1 0 8 3 1 2 8000000000000000 4 0 0 0 0 0 0 0 0 0 0 0  f800000000000000 4 3 8 1 0
1 0 4 3 1 2 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0  1 1 3 4 1 0
1 0 5 3 1 2 ffffffffffffffff 1 0 0 0 0 0 0 0 0 0 0 0  0 1 3 5 1 0
1 0 b 3 1 2 20 99 fffffffffffffff0 0 0 0 0 0 0 0 0 0 0  10 99 3 b 1 0
1 0 11 3 1 2 ffffffffffff0000 0 8 0 0 0 0 0 0 0 0 0 0  ffffffffffffff00 0 3 11 1 0
1 0 14 3 0 0 0 0 12345000 0 0 0 0 0 0 0 0 0 0  12345000 0 3 14 1 0
1 0 15 3 1 2 7fffffff 1 0 0 0 0 0 0 0 0 0 0 0  ffffffff80000000 1 3 15 1 0
1 0 16 3 1 2 0 1 0 0 0 0 0 0 0 0 0 0 0  ffffffffffffffff 1 3 16 1 0
1 0 17 3 1 2 1 3f 0 0 0 0 0 0 0 0 0 0 0  ffffffff80000000 3f 3 17 1 0
1 0 18 3 1 2 ffffffff80000000 4 0 0 0 0 0 0 0 0 0 0 0  8000000 4 3 18 1 0
1 0 19 3 1 2 80000000 4 0 0 0 0 0 0 0 0 0 0 0  fffffffff8000000 4 3 19 1 0
1 0 1a 3 1 2 ffffffff00000005 0 3 0 0 0 0 0 0 0 0 0 0  8 0 3 1a 1 0
1 0 1 3 1 2 100 1 0 1 0 a0 1 1 b0 c0 1 d0 0  a1 1 3 1 1 0
1 0 1 3 1 2 100 1 0 4 0 a0 1 1 b0 c0 1 d0 0  c1 1 3 1 1 0
1 0 1 3 1 2 100 1 0 4 0 a0 1 0 b0 c0 1 d0 0  b1 1 3 1 1 0
1 0 1 3 1 2 100 1 0 4 0 a0 5 0 b0 c0 1 d0 0  d1 1 3 1 1 0
1 0 1 3 0 2 100 1 0 0 1 a0 0 1 b0 c0 0 d0 0  101 1 3 1 1 0
1 0 1 3 1 2 10 1 0 2 1 ee 0 0 0 40 0 0 1  50 40 3 1 1 0
0 1 2 3 1 2 9 1 0 0 0 0 0 0 0 0 0 0 0  50 40 3 1 1 0
1 1 1 3 1 2 5 3 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
1 0 21 5 1 2 1000 77 8 0 0 0 0 0 0 0 0 0 0  0 77 5 21 0 1
1 0 28 0 1 2 1000 11 10 0 0 0 0 0 0 0 2 5a5a 0  0 5a5a 0 28 0 0
1 0 25 0 1 2 1000 11 0 2 0 33 0 0 0 0 0 0 0  0 33 0 25 0 0

/* ex_hazard_ctrl.sv */
/*
 * Load-use stall state of the execute stage
 * Drives ready, the memory data select and the output register strobes
 */
`timescale 1ns/1ps
`default_nettype none

module ex_hazard_ctrl
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic enable,
    input  wire logic branch_taken,
    input  wire logic load_hit_rs1,
    input  wire logic load_hit_rs2,
    output logic      ready,
    output logic      use_mdata,
    output logic      capture,
    output logic      flush
);

    logic stalled;

    // First cycle of a load hit is a bubble
    assign ready     = !((load_hit_rs1 || load_hit_rs2) && !stalled);
    assign use_mdata = stalled;
    assign capture   = enable && ready;
    assign flush     = capture && branch_taken;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stalled <= 1'b0;
        end
        else if (capture)
        begin
            stalled <= 1'b0;
        end
        else if (!ready)
        begin
            stalled <= 1'b1;
        end
    end

    // The stalled operation is held for one cycle while its load data arrives
    a_single_stall: assert property (@(posedge clk) disable iff (reset)
        !ready |=> ready && (load_hit_rs1 || load_hit_rs2));

endmodule

`default_nettype wire

/* ex_int_alu.sv */
/*
 * RV64I integer ALU
 * Register and immediate forms, W forms with sign extension, lui
 */
`timescale 1ns/1ps
`default_nettype none

module ex_int_alu
(
    input  wire exec_op_pkg::ex_op_t op,
    input  wire exec_cfg_pkg::word_t src1,
    input  wire exec_cfg_pkg::word_t src2,
    input  wire exec_cfg_pkg::word_t imm,
    output exec_cfg_pkg::word_t      result,
    output logic                     writes_rd,
    output logic                     is_load
);
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    logic        use_imm;
    logic        is_word;
    word_t       operand_b;
    shamt_t      shamt;
    word_t       wide_res;
    logic [31:0] word_res;

    assign use_imm = op inside {op_addi, op_slli, op_slti, op_sltiu, op_xori, op_srli,
                                op_srai, op_ori, op_andi, op_addiw, op_slliw, op_srliw,
                                op_sraiw};
    assign is_word = op inside {op_addw, op_subw, op_sllw, op_srlw, op_sraw,
                                op_addiw, op_slliw, op_srliw, op_sraiw};

    assign operand_b = use_imm ? imm : src2;

    // W forms shift by 5 bits only
    assign shamt = is_word ? {1'b0, operand_b[4:0]} : operand_b[5:0];

    always_comb
    begin
        wide_res = '0;
        word_res = '0;
        case (op)
            op_add, op_addi:   wide_res = src1 + operand_b;
            op_sub:            wide_res = src1 - operand_b;
            op_sll, op_slli:   wide_res = src1 << shamt;
            op_slt, op_slti:   wide_res = word_t'($signed(src1) < $signed(operand_b));
            op_sltu, op_sltiu: wide_res = word_t'(src1 < operand_b);
            op_xor, op_xori:   wide_res = src1 ^ operand_b;
            op_srl, op_srli:   wide_res = src1 >> shamt;
            op_sra, op_srai:   wide_res = $signed(src1) >>> shamt;
            op_or, op_ori:     wide_res = src1 | operand_b;
            op_and, op_andi:   wide_res = src1 & operand_b;
            op_lui:            wide_res = imm;
            op_addw, op_addiw: word_res = src1[31:0] + operand_b[31:0];
            op_subw:           word_res = src1[31:0] - operand_b[31:0];
            op_sllw, op_slliw: word_res = src1[31:0] << shamt;
            op_srlw, op_srliw: word_res = src1[31:0] >> shamt;
            op_sraw, op_sraiw: word_res = $signed(src1[31:0]) >>> shamt;
            // Loads, stores and unknown leave a zero result
            default:           wide_res = '0;
        endcase
    end

    assign result    = is_word ? {{32{word_res[31]}}, word_res} : wide_res;
    assign writes_rd = op_writes_rd(op);
    assign is_load   = op_is_load(op);

endmodule

`default_nettype wire

/* ex_operand_fwd.sv */
/*
 * Forwarding select for one source operand
 * Priority is ALU stage, memory stage, write-back, register file
 */
`timescale 1ns/1ps
`default_nettype none

module ex_operand_fwd
(
    input  wire exec_cfg_pkg::regno_t src_regno,
    input  wire exec_cfg_pkg::regno_t alu_rd_regno,
    input  wire exec_cfg_pkg::regno_t mm_rd_regno,
    input  wire exec_cfg_pkg::regno_t wb_rd_regno,
    input  wire logic                 alu_load,
    input  wire logic                 mm_load,
    input  wire logic                 use_mdata,
    input  wire exec_cfg_pkg::word_t  reg_value,
    input  wire exec_cfg_pkg::word_t  alu_fwd_result,
    input  wire exec_cfg_pkg::word_t  mm_alu_result,
    input  wire exec_cfg_pkg::word_t  mm_mdata,
    input  wire exec_cfg_pkg::word_t  wb_data,
    output exec_cfg_pkg::word_t       value,
    output logic                      load_hit
);

    always_comb
    begin
        value    = reg_value;
        load_hit = 1'b0;
        // x0 always reads the register file
        if (src_regno != '0)
        begin
            if (src_regno == alu_rd_regno)
            begin
                if (alu_load)
                begin
                    // Load data only exists once the stall cycle is over
                    load_hit = 1'b1;
                    if (use_mdata)
                        value = mm_mdata;
                end
                else
                begin
                    value = alu_fwd_result;
                end
            end
            else if (src_regno == mm_rd_regno)
            begin
                value = mm_load ? mm_mdata : mm_alu_result;
            end
            else if (src_regno == wb_rd_regno)
            begin
                value = wb_data;
            end
        end
    end

endmodule

`default_nettype wire

/* ex_result_reg.sv */
/*
 * Execute stage output register
 * Captures on enable and ready, loads a bubble on flush or reset
 */
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 capture,
    input  wire logic                 flush,
    input  wire exec_cfg_pkg::word_t  result,
    input  wire exec_cfg_pkg::word_t  rs2_in,
    input  wire exec_cfg_pkg::regno_t rd_in,
    input  wire exec_op_pkg::ex_op_t  op_in,
    input  wire logic                 writes_rd,
    input  wire logic                 is_load,
    output exec_cfg_pkg::word_t       alu_result,
    output exec_cfg_pkg::word_t       rs2_out,
    output exec_cfg_pkg::regno_t      rd_out,
    output exec_op_pkg::ex_op_t       op_out,
    output logic                      update_rd,
    output logic                      mm_load_out
);
    import exec_op_pkg::*;

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            alu_result  <= '0;
            rs2_out     <= '0;
            rd_out      <= '0;
            op_out      <= op_unknown;
            update_rd   <= 1'b0;
            mm_load_out <= 1'b0;
        end
        else if (capture)
        begin
            alu_result  <= result;
            rs2_out     <= rs2_in;
            rd_out      <= rd_in;
            op_out      <= op_in;
            update_rd   <= writes_rd;
            mm_load_out <= is_load;
        end
    end

    // A captured slot writes a register or starts a load but never both
    a_rd_or_load: assert property (@(posedge clk) disable iff (reset)
        capture |-> !(writes_rd && is_load));

endmodule

`default_nettype wire

/* ex_stage.sv */
/*
 * Execute stage top level
 * Hazard control, rs1 and rs2 forwarding, integer ALU and output register
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  enable,
    input  wire logic                  branch_taken,
    input  wire exec_cfg_pkg::word_t   rs1_value,
    input  wire exec_cfg_pkg::word_t   rs2_value,
    input  wire exec_cfg_pkg::word_t   imm_value,
    input  wire exec_cfg_pkg::regno_t  rd_regno,
    input  wire exec_cfg_pkg::regno_t  rs1_regno,
    input  wire exec_cfg_pkg::regno_t  rs2_regno,
    input  wire exec_op_pkg::ex_op_t   op,
    input  wire exec_cfg_pkg::regno_t  alu_rd_regno,
    input  wire logic                  alu_load,
    input  wire exec_cfg_pkg::word_t   alu_fwd_result,
    input  wire exec_cfg_pkg::regno_t  mm_rd_regno,
    input  wire logic                  mm_load,
    input  wire exec_cfg_pkg::word_t   mm_alu_result,
    input  wire exec_cfg_pkg::word_t   mm_mdata,
    input  wire exec_cfg_pkg::regno_t  wb_rd_regno,
    input  wire exec_cfg_pkg::word_t   wb_data,
    output exec_cfg_pkg::word_t        alu_result,
    output exec_cfg_pkg::word_t        rs2_out,
    output exec_cfg_pkg::regno_t       rd_out,
    output exec_op_pkg::ex_op_t        op_out,
    output logic                       update_rd,
    output logic                       mm_load_out,
    output logic                       ready
);
    import exec_cfg_pkg::*;

    word_t fwd_rs1_value;
    word_t fwd_rs2_value;
    word_t exec_result;
    logic  load_hit_rs1;
    logic  load_hit_rs2;
    logic  use_mdata;
    logic  capture;
    logic  flush;
    logic  exec_writes_rd;
    logic  exec_is_load;

    ex_hazard_ctrl u_hazard (
        .clk(clk), .reset(reset), .enable(enable), .branch_taken(branch_taken),
        .load_hit_rs1(load_hit_rs1), .load_hit_rs2(load_hit_rs2),
        .ready(ready), .use_mdata(use_mdata), .capture(capture), .flush(flush)
    );

    ex_operand_fwd u_fwd_rs1 (
        .src_regno(rs1_regno), .alu_rd_regno(alu_rd_regno),
        .mm_rd_regno(mm_rd_regno), .wb_rd_regno(wb_rd_regno),
        .alu_load(alu_load), .mm_load(mm_load), .use_mdata(use_mdata),
        .reg_value(rs1_value), .alu_fwd_result(alu_fwd_result),
        .mm_alu_result(mm_alu_result), .mm_mdata(mm_mdata), .wb_data(wb_data),
        .value(fwd_rs1_value), .load_hit(load_hit_rs1)
    );

    ex_operand_fwd u_fwd_rs2 (
        .src_regno(rs2_regno), .alu_rd_regno(alu_rd_regno),
        .mm_rd_regno(mm_rd_regno), .wb_rd_regno(wb_rd_regno),
        .alu_load(alu_load), .mm_load(mm_load), .use_mdata(use_mdata),
        .reg_value(rs2_value), .alu_fwd_result(alu_fwd_result),
        .mm_alu_result(mm_alu_result), .mm_mdata(mm_mdata), .wb_data(wb_data),
        .value(fwd_rs2_value), .load_hit(load_hit_rs2)
    );

    ex_int_alu u_alu (
        .op(op), .src1(fwd_rs1_value), .src2(fwd_rs2_value), .imm(imm_value),
        .result(exec_result), .writes_rd(exec_writes_rd), .is_load(exec_is_load)
    );

    // Forwarded rs2 goes on as store data
    ex_result_reg u_result_reg (
        .clk(clk), .reset(reset), .capture(capture), .flush(flush),
        .result(exec_result), .rs2_in(fwd_rs2_value), .rd_in(rd_regno), .op_in(op),
        .writes_rd(exec_writes_rd), .is_load(exec_is_load),
        .alu_result(alu_result), .rs2_out(rs2_out), .rd_out(rd_out), .op_out(op_out),
        .update_rd(update_rd), .mm_load_out(mm_load_out)
    );

endmodule

`default_nettype wire

/* exec_cfg_pkg.sv */
/*
 * Data widths of the execute stage and the vector types built on them
 */
`default_nettype none

package exec_cfg_pkg;

    localparam int XLEN    = 64;
    localparam int REGNO_W = 5;
    localparam int SHAMT_W = 6;

    // Register values, immediates and results
    typedef logic [XLEN-1:0] word_t;

    // Architectural register number
    typedef logic [REGNO_W-1:0] regno_t;

    // Shift amount, top bit unused by the W forms
    typedef logic [SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

/* exec_op_pkg.sv */
/*
 * Operation encoding of the execute stage
 * Class functions for loads, stores and register write-back
 */
`default_nettype none

package exec_op_pkg;

    // Zero encoding doubles as the flushed bubble
    typedef enum logic [5:0] {
        op_unknown = 6'd0,
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slli, op_slti, op_sltiu, op_xori,
        op_srli, op_srai, op_ori, op_andi, op_lui,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } ex_op_t;

    function automatic logic op_is_load(ex_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic op_is_store(ex_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // Every ALU operation writes rd
    function automatic logic op_writes_rd(ex_op_t op);
        return !(op_is_load(op) || op_is_store(op) || op == op_unknown);
    endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_ex_stage -o Vtb_ex_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ex_stage > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Errors found" "$log_file"; then
    exit 1
fi
exit 0

/* sim.f */
exec_cfg_pkg.sv
exec_op_pkg.sv
ex_hazard_ctrl.sv
ex_operand_fwd.sv
ex_int_alu.sv
ex_result_reg.sv
ex_stage.sv
tb_ex_stage.sv

/* tb_ex_stage.sv */
/*
 * Testbench for the execute stage
 * Reads vectors from the golden file, drives the DUT and checks its registered outputs
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import exec_cfg_pkg::*;
    import exec_op_pkg::*;

    localparam int STALL_TIMEOUT = 20;
    localparam int NUM_FIELDS    = 25;

    logic   clk, reset, enable, branch_taken, alu_load, mm_load;
    word_t  rs1_value, rs2_value, imm_value, alu_fwd_result, mm_alu_result, mm_mdata, wb_data;
    regno_t rd_regno, rs1_regno, rs2_regno, alu_rd_regno, mm_rd_regno, wb_rd_regno;
    ex_op_t op;
    word_t  alu_result, rs2_out;
    regno_t rd_out;
    ex_op_t op_out;
    logic   update_rd, mm_load_out, ready;

    int    value_errors, other_errors, vector_count, fd;
    logic  aborted;
    string line;

    ex_stage u_dut (.*);

    always #5 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_regno(input string name, input regno_t got, input regno_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input ex_op_t got, input ex_op_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        {enable, branch_taken, alu_load, mm_load} = '0;
        {rs1_value, rs2_value, imm_value, alu_fwd_result} = '0;
        {mm_alu_result, mm_mdata, wb_data} = '0;
        {rd_regno, rs1_regno, rs2_regno, alu_rd_regno, mm_rd_regno, wb_rd_regno} = '0;
        op = op_unknown;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the capturing edge
    task automatic run_vector(input string text);
        int          fields;
        int          stall_cycles;
        logic [5:0]  op_code;
        logic [5:0]  exp_op_code;
        logic        exp_stall, exp_update, exp_load;
        word_t       exp_result, exp_rs2;
        regno_t      exp_rd;
        fields = $sscanf(text,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            enable, branch_taken, op_code, rd_regno, rs1_regno, rs2_regno,
            rs1_value, rs2_value, imm_value, alu_rd_regno, alu_load, alu_fwd_result,
            mm_rd_regno, mm_load, mm_alu_result, mm_mdata, wb_rd_regno, wb_data,
            exp_stall, exp_result, exp_rs2, exp_rd, exp_op_code, exp_update, exp_load);
        vector_count++;
        if (fields != NUM_FIELDS)
        begin
            other_errors++;
            $display("Vector %0d in the golden file has %0d fields", vector_count, fields);
            aborted = 1'b1;
            return;
        end
        op = ex_op_t'(op_code);
        #1;
        check_bit("ready", ready, !exp_stall);
        stall_cycles = 0;
        while (ready !== 1'b1 && stall_cycles < STALL_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            stall_cycles++;
        end
        if (ready !== 1'b1)
        begin
            other_errors++;
            $display("Vector %0d: ready stayed low for %0d cycles", vector_count, stall_cycles);
            aborted = 1'b1;
            return;
        end
        if (exp_stall && stall_cycles != 1)
        begin
            other_errors++;
            $display("Vector %0d: stall lasted %0d cycles, not one", vector_count, stall_cycles);
        end
        @(posedge clk);
        #1;
        check_word("alu_result", alu_result, exp_result);
        check_word("rs2_out", rs2_out, exp_rs2);
        check_regno("rd_out", rd_out, exp_rd);
        check_op("op_out", op_out, ex_op_t'(exp_op_code));
        check_bit("update_rd", update_rd, exp_update);
        check_bit("mm_load_out", mm_load_out, exp_load);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        clear_inputs();
        value_errors = 0;
        other_errors = 0;
        vector_count = 0;
        aborted = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        // Reset state before the first vector
        check_bit("ready", ready, 1'b1);
        check_bit("update_rd", update_rd, 1'b0);
        check_bit("mm_load_out", mm_load_out, 1'b0);
        check_word("alu_result", alu_result, '0);
        check_word("rs2_out", rs2_out, '0);
        check_regno("rd_out", rd_out, '0);
        check_op("op_out", op_out, op_unknown);
        reset = 1'b0;
        fd = $fopen("ex_golden.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open ex_golden.txt");
        end
        else
        begin
            while (!aborted && $fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                    run_vector(line);
            end
            $fclose(fd);
        end
        if (vector_count == 0)
        begin
            other_errors++;
            $display("No vectors were read from the golden file");
        end
        $display("Vectors: %0d, value errors: %0d, other errors: %0d",
                 vector_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
